/* hdl/pinball_pkg.sv */
`default_nettype none

package pinball_pkg;

   typedef logic signed [10:0] coord_t;   // signed so overshoot past an edge stays sane
   typedef logic [9:0]         pix_x_t;
   typedef logic [8:0]         pix_y_t;
   typedef logic signed [4:0]  vel_t;
   typedef logic [2:0]         rgb_t;

   typedef struct packed {
      pix_x_t x;
      pix_y_t y;
      logic   video_on;
   } pixel_t;

   typedef struct packed {
      coord_t x;
      coord_t y;
      vel_t   vx;
      vel_t   vy;
   } ball_t;

   typedef struct packed {
      logic hit;
      vel_t vx;
      vel_t vy;
      logic score;
   } bounce_t;

   typedef enum logic {bar_left, bar_right} bar_dir_t;
   typedef enum logic {parked, rolling} ball_phase_t;

   localparam coord_t screen_w    = 640;
   localparam coord_t screen_h    = 480;
   localparam coord_t wall_margin = 10;
   localparam int frame_cycles_default = 830000;

   // ball
   localparam coord_t ball_home_x = 300;
   localparam coord_t ball_home_y = 300;
   localparam coord_t ball_radius = 6;
   localparam vel_t   launch_vx   = 3;
   localparam vel_t   launch_vy   = 4;
   localparam coord_t drain_y     = 479;
   localparam ball_t  ball_parked = '{x: ball_home_x, y: ball_home_y, vx: '0, vy: '0};
   localparam ball_t  ball_launch = '{x: ball_home_x, y: ball_home_y,
                                      vx: launch_vx, vy: launch_vy};

   // flippers, raised ones lie on y = 640 - x and y = x
   localparam coord_t flip_rest_y       = 470;
   localparam coord_t flip_top_y        = 390;
   localparam coord_t left_flip_x_lo    = 170;
   localparam coord_t left_flip_x_hi    = 280;
   localparam coord_t right_flip_x_lo   = 360;
   localparam coord_t right_flip_x_hi   = 500;
   localparam coord_t left_flip_sum     = 640;
   localparam coord_t right_flip_off    = 0;
   localparam coord_t left_flip_diag_x  = 250;   // contact zone limits on the diagonals
   localparam coord_t right_flip_diag_x = 380;
   localparam vel_t   flip_kick_vx      = 2;
   localparam vel_t   flip_kick_vy      = 6;

   // slides
   localparam coord_t left_slide_off  = 300;   // y = x + 300
   localparam coord_t right_slide_sum = 940;   // y = 940 - x
   localparam vel_t   left_slide_vx   = 2;
   localparam vel_t   left_slide_vy   = 4;
   localparam vel_t   right_slide_vx  = 1;
   localparam vel_t   right_slide_vy  = 5;

   // top bar
   localparam coord_t bar_top     = 10;
   localparam coord_t bar_thick   = 10;
   localparam coord_t bar_width   = 80;
   localparam coord_t bar_speed   = 6;
   localparam coord_t bar_home    = 260;
   localparam coord_t bar_hit_lo  = 12;
   localparam coord_t bar_hit_hi  = 22;
   localparam vel_t   bar_kick_vy = 5;

   localparam coord_t panel_bottom = 300;

   // colours
   localparam rgb_t col_black  = 3'd0;
   localparam rgb_t col_flip   = 3'd1;
   localparam rgb_t col_wall   = 3'd2;
   localparam rgb_t col_target = 3'd3;
   localparam rgb_t col_bar    = 3'd4;
   localparam rgb_t col_fast   = 3'd5;
   localparam rgb_t col_ball   = 3'd7;

   // targets: left, mid, right, fast
   localparam int     target_count = 4;
   localparam coord_t target_x  [target_count] = '{150, 300, 520, 125};
   localparam coord_t target_y  [target_count] = '{230, 160, 200, 80};
   localparam coord_t target_r  [target_count] = '{30, 35, 40, 20};
   localparam vel_t   target_vx [target_count] = '{4, 5, 4, 7};
   localparam vel_t   target_vy [target_count] = '{3, 4, 3, 8};
   localparam rgb_t   target_col[target_count] = '{col_target, col_target, col_target,
                                                   col_fast};

   // point inside or on a circle, squared distance against squared radius
   function automatic logic in_circle(coord_t px, coord_t py, coord_t cx, coord_t cy,
                                      coord_t r);
      logic signed [11:0] dx;
      logic signed [11:0] dy;
      logic signed [24:0] d2;
      logic signed [24:0] r2;
      dx = {px[10], px} - {cx[10], cx};
      dy = {py[10], py} - {cy[10], cy};
      d2 = dx * dx + dy * dy;
      r2 = r * r;
      return d2 <= r2;
   endfunction

endpackage

`default_nettype wire

/* hdl/frame_ticker.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_ticker #(
   parameter int frame_cycles = pinball_pkg::frame_cycles_default
) (
   input  logic clk,
   input  logic reset,
   output logic frame_tick
);

   logic [$clog2(frame_cycles)-1:0] count;

   // last cycle of the frame
   assign frame_tick = (count == frame_cycles - 1);

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (frame_tick) begin
         count <= '0;   // wrap
      end else begin
         count <= count + 1'b1;
      end
   end

   a_tick_single : assert property (@(posedge clk) disable iff (reset)
      frame_tick |=> !frame_tick)
      else $error("frame_tick held for two cycles");

endmodule

`default_nettype wire

/* hdl/board_actuators.sv */
`timescale 1ns/1ns
`default_nettype none

module board_actuators (
   input  logic                clk,
   input  logic                reset,
   input  logic                frame_tick,
   input  logic                button_l,
   input  logic                button_r,
   output logic                flip_l,
   output logic                flip_r,
   output pinball_pkg::coord_t bar_x
);
   import pinball_pkg::*;

   bar_dir_t bar_dir;

   // flippers only follow the buttons once per frame
   always_ff @(posedge clk) begin
      if (reset) begin
         flip_l <= 1'b0;
         flip_r <= 1'b0;
      end else if (frame_tick) begin
         flip_l <= button_l;
         flip_r <= button_r;
      end
   end

   // bar sweep, a frame spent at the end stop just turns it around
   always_ff @(posedge clk) begin
      if (reset) begin
         bar_x   <= bar_home;
         bar_dir <= bar_left;
      end else if (frame_tick) begin
         case (bar_dir)
            bar_left: begin
               if (bar_x > bar_speed) begin
                  bar_x <= bar_x - bar_speed;
               end else begin
                  bar_dir <= bar_right;
               end
            end
            bar_right: begin
               if (bar_x < screen_w - 1 - bar_speed - bar_width) begin
                  bar_x <= bar_x + bar_speed;
               end else begin
                  bar_dir <= bar_left;
               end
            end
            default: bar_dir <= bar_left;
         endcase
      end
   end

   a_bar_on_screen : assert property (@(posedge clk) disable iff (reset)
      (bar_x >= 0) && (bar_x + bar_width < screen_w))
      else $error("top bar left the screen, bar_x=%0d", bar_x);

endmodule

`default_nettype wire

/* hdl/collision_detect.sv */
`timescale 1ns/1ns
`default_nettype none

module collision_detect (
   input  pinball_pkg::ball_t   ball,
   input  logic                 flip_l,
   input  logic                 flip_r,
   input  pinball_pkg::coord_t  bar_x,
   output pinball_pkg::bounce_t bounce
);
   import pinball_pkg::*;

   logic tgt_hit;
   vel_t tgt_vx;
   vel_t tgt_vy;
   vel_t vx_mag;
   vel_t vy_mag;

   assign vx_mag = (ball.vx < 0) ? vel_t'(-ball.vx) : ball.vx;
   assign vy_mag = (ball.vy < 0) ? vel_t'(-ball.vy) : ball.vy;

   // target search, walked backwards so the first table entry wins
   always_comb begin
      tgt_hit = 1'b0;
      tgt_vx  = '0;
      tgt_vy  = '0;
      for (int i = target_count - 1; i >= 0; i--) begin
         if (in_circle(ball.x, ball.y, target_x[i], target_y[i], target_r[i])) begin
            tgt_hit = 1'b1;
            // quadrant picks the signs only
            tgt_vx  = (ball.x < target_x[i]) ? vel_t'(-target_vx[i]) : target_vx[i];
            tgt_vy  = (ball.y < target_y[i]) ? vel_t'(-target_vy[i]) : target_vy[i];
         end
      end
   end

   always_comb begin
      bounce.hit   = 1'b1;
      bounce.vx    = ball.vx;
      bounce.vy    = ball.vy;
      bounce.score = 1'b0;
      if (!flip_l && ball.y >= flip_rest_y &&
          ball.x >= left_flip_x_lo && ball.x < left_flip_x_hi) begin
         bounce.vy = vel_t'(-vy_mag);   // resting left flipper
      end else if (!flip_r && ball.y >= flip_rest_y &&
                   ball.x > right_flip_x_lo && ball.x < right_flip_x_hi) begin
         bounce.vy = vel_t'(-vy_mag);
      end else if (flip_l && ball.y >= left_flip_sum - ball.x && ball.x < left_flip_diag_x &&
                   ball.y > flip_top_y && ball.y <= flip_rest_y) begin
         bounce.vx = flip_kick_vx;
         bounce.vy = vel_t'(-flip_kick_vy);
      end else if (flip_r && ball.y >= ball.x + right_flip_off &&
                   ball.x > right_flip_diag_x &&
                   ball.y > flip_top_y && ball.y <= flip_rest_y) begin
         bounce.vx = vel_t'(-flip_kick_vx);
         bounce.vy = vel_t'(-flip_kick_vy);
      end else if (ball.y >= ball.x + left_slide_off) begin
         bounce.vx = left_slide_vx;
         bounce.vy = vel_t'(-left_slide_vy);
      end else if (ball.y >= right_slide_sum - ball.x) begin
         bounce.vx = vel_t'(-right_slide_vx);
         bounce.vy = vel_t'(-right_slide_vy);
      end else if (tgt_hit) begin
         bounce.vx    = tgt_vx;
         bounce.vy    = tgt_vy;
         bounce.score = 1'b1;
      end else if (ball.x >= bar_x && ball.x <= bar_x + bar_width &&
                   ball.y >= bar_hit_lo && ball.y <= bar_hit_hi) begin
         bounce.vy    = bar_kick_vy;   // knocked back down, vx kept
         bounce.score = 1'b1;
      end else if (ball.x <= wall_margin) begin
         bounce.vx = vx_mag;
      end else if (ball.x >= screen_w - wall_margin) begin
         bounce.vx = vel_t'(-vx_mag);
      end else if (ball.y <= wall_margin) begin
         bounce.vy = vy_mag;
      end else begin
         bounce.hit = 1'b0;   // free flight
      end
   end

endmodule

`default_nettype wire

/* hdl/ball_physics.sv */
`timescale 1ns/1ns
`default_nettype none

module ball_physics (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 frame_tick,
   input  logic                 start_ball,
   input  logic                 shake,
   input  pinball_pkg::bounce_t bounce,
   output pinball_pkg::ball_t   ball,
   output logic                 score
);
   import pinball_pkg::*;

   ball_phase_t phase;
   logic        start_d;      // start_ball one clock back
   logic        start_pend;   // edge waiting for the next tick
   vel_t        new_vx;

   assign new_vx = bounce.hit ? bounce.vx : ball.vx;

   always_ff @(posedge clk) begin
      if (reset) begin
         phase      <= parked;
         ball       <= ball_parked;
         start_d    <= 1'b0;
         start_pend <= 1'b0;
         score      <= 1'b0;
      end else begin
         start_d <= start_ball;
         if (frame_tick) begin
            score <= (phase == rolling) && bounce.score;   // held for the whole frame
            if (start_pend) begin
               start_pend <= 1'b0;
               if (phase == parked) begin
                  phase <= rolling;
                  ball  <= ball_launch;
               end else begin
                  phase <= parked;
                  ball  <= ball_parked;
               end
            end else if (phase == rolling) begin
               if (ball.y >= drain_y) begin
                  phase <= parked;   // out the bottom
                  ball  <= ball_parked;
               end else begin
                  ball.x  <= ball.x + ball.vx;   // move with the old velocity
                  ball.y  <= ball.y + ball.vy;
                  ball.vx <= shake ? vel_t'(-new_vx) : new_vx;
                  ball.vy <= bounce.hit ? bounce.vy : ball.vy;
               end
            end
         end
         // a fresh edge is kept even when a tick serves the old one
         if (start_ball && !start_d) begin
            start_pend <= 1'b1;
         end
      end
   end

   a_parked_still : assert property (@(posedge clk) disable iff (reset)
      (phase == parked) |-> (ball.vx == 0 && ball.vy == 0 &&
                             ball.x == ball_home_x && ball.y == ball_home_y))
      else $error("parked ball is not at rest at home");

endmodule

`default_nettype wire

/* hdl/pixel_renderer.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_renderer (
   input  logic                clk,
   input  logic                reset,
   input  pinball_pkg::pixel_t pix,
   input  pinball_pkg::ball_t  ball,
   input  pinball_pkg::coord_t bar_x,
   input  logic                flip_l,
   input  logic                flip_r,
   output pinball_pkg::rgb_t   rgb
);
   import pinball_pkg::*;

   coord_t px;
   coord_t py;
   logic   on_ball;
   logic   on_bar;
   logic   on_target;
   rgb_t   target_rgb;
   logic   on_flip;
   logic   on_panel;
   logic   on_strip;
   logic   on_slide;
   rgb_t   rgb_next;

   assign px = coord_t'({1'b0, pix.x});
   assign py = coord_t'({2'b00, pix.y});

   assign on_ball = in_circle(px, py, ball.x, ball.y, ball_radius);
   assign on_bar  = px > bar_x && px < bar_x + bar_width &&
                    py > bar_top && py < bar_top + bar_thick;

   always_comb begin
      on_target  = 1'b0;
      target_rgb = col_target;
      for (int i = target_count - 1; i >= 0; i--) begin
         if (in_circle(px, py, target_x[i], target_y[i], target_r[i])) begin
            on_target  = 1'b1;
            target_rgb = target_col[i];
         end
      end
   end

   // down flippers are one row, raised ones a diagonal between the rows
   assign on_flip =
      (!flip_l && py == flip_rest_y && px >= left_flip_x_lo && px < left_flip_x_hi) ||
      (!flip_r && py == flip_rest_y && px > right_flip_x_lo && px < right_flip_x_hi) ||
      (flip_l && py == left_flip_sum - px && py > flip_top_y && py < flip_rest_y) ||
      (flip_r && py == px + right_flip_off && py > flip_top_y && py < flip_rest_y);

   assign on_panel = py > 0 && py < panel_bottom &&
                     ((px > 0 && px < wall_margin) ||
                      (px > screen_w - wall_margin && px < screen_w));
   assign on_strip = py > 0 && py < wall_margin;
   assign on_slide = py >= px + left_slide_off || py >= right_slide_sum - px;

   always_comb begin
      if (!pix.video_on) rgb_next = col_black;
      else if (on_ball) rgb_next = col_ball;
      else if (on_bar) rgb_next = col_bar;
      else if (on_target) rgb_next = target_rgb;
      else if (on_flip) rgb_next = col_flip;
      else if (on_panel || on_strip || on_slide) rgb_next = col_wall;
      else rgb_next = col_black;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rgb <= col_black;
      end else begin
         rgb <= rgb_next;   // one cycle behind pix
      end
   end

endmodule

`default_nettype wire

/* hdl/pinball_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pinball_top #(
   parameter int frame_cycles = pinball_pkg::frame_cycles_default
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                start_ball,
   input  logic                button_l,
   input  logic                button_r,
   input  logic                shake,
   input  pinball_pkg::pixel_t pix,
   output pinball_pkg::rgb_t   rgb,
   output logic                score
);
   import pinball_pkg::*;

   logic    frame_tick;
   logic    flip_l;
   logic    flip_r;
   coord_t  bar_x;
   ball_t   ball;
   bounce_t bounce;

   frame_ticker #(
      .frame_cycles (frame_cycles)
   ) u_ticker (
      .clk        (clk),
      .reset      (reset),
      .frame_tick (frame_tick)
   );

   board_actuators u_actuators (
      .clk        (clk),
      .reset      (reset),
      .frame_tick (frame_tick),
      .button_l   (button_l),
      .button_r   (button_r),
      .flip_l     (flip_l),
      .flip_r     (flip_r),
      .bar_x      (bar_x)
   );

   collision_detect u_collide (
      .ball   (ball),
      .flip_l (flip_l),
      .flip_r (flip_r),
      .bar_x  (bar_x),
      .bounce (bounce)
   );

   ball_physics u_ball (
      .clk        (clk),
      .reset      (reset),
      .frame_tick (frame_tick),
      .start_ball (start_ball),
      .shake      (shake),
      .bounce     (bounce),
      .ball       (ball),
      .score      (score)
   );

   pixel_renderer u_render (
      .clk    (clk),
      .reset  (reset),
      .pix    (pix),
      .ball   (ball),
      .bar_x  (bar_x),
      .flip_l (flip_l),
      .flip_r (flip_r),
      .rgb    (rgb)
   );

endmodule

`default_nettype wire

/* tb/pinball_model.svh */
`ifndef pinball_model_svh
`define pinball_model_svh

// expected game state, stepped once per frame tick
ball_t exp_ball;
logic  exp_rolling;
logic  exp_flip_l;
logic  exp_flip_r;
int    exp_bar;
logic  exp_bar_right;   // sweep direction
logic  exp_score;
int    drains;
int    hits;

function automatic logic within_radius(int px, int py, int cx, int cy, int r);
   return (px - cx) * (px - cx) + (py - cy) * (py - cy) <= r * r;
endfunction

function automatic ball_t home_ball(logic launch);
   ball_t b;
   b.x  = 11'sd300;
   b.y  = 11'sd300;
   b.vx = launch ? 5'sd3 : 5'sd0;
   b.vy = launch ? 5'sd4 : 5'sd0;
   return b;
endfunction

// contact rules in priority order, first match wins
function automatic bounce_t bounce_for(ball_t b, logic fl, logic fr, int bx);
   int      x;
   int      y;
   int      ax;
   int      ay;
   bounce_t r;
   x  = int'(b.x);
   y  = int'(b.y);
   ax = (b.vx < 0) ? -int'(b.vx) : int'(b.vx);
   ay = (b.vy < 0) ? -int'(b.vy) : int'(b.vy);
   r  = '{hit: 1'b1, vx: b.vx, vy: b.vy, score: 1'b0};
   if (!fl && y >= 470 && x >= 170 && x < 280) begin
      r.vy = vel_t'(-ay);
   end else if (!fr && y >= 470 && x > 360 && x < 500) begin
      r.vy = vel_t'(-ay);
   end else if (fl && y >= 640 - x && x < 250 && y > 390 && y <= 470) begin
      r.vx = 5'sd2;
      r.vy = -5'sd6;
   end else if (fr && y >= x && x > 380 && y > 390 && y <= 470) begin
      r.vx = -5'sd2;
      r.vy = -5'sd6;
   end else if (y >= x + 300) begin
      r.vx = 5'sd2;   // left slide
      r.vy = -5'sd4;
   end else if (y >= 940 - x) begin
      r.vx = -5'sd1;
      r.vy = -5'sd5;
   end else begin
      for (int i = 0; i < target_count; i++) begin
         if (!r.score && within_radius(x, y, target_x[i], target_y[i], target_r[i])) begin
            r.vx    = (x < target_x[i]) ? vel_t'(-target_vx[i]) : target_vx[i];
            r.vy    = (y < target_y[i]) ? vel_t'(-target_vy[i]) : target_vy[i];
            r.score = 1'b1;
         end
      end
      if (!r.score) begin
         if (x >= bx && x <= bx + 80 && y >= 12 && y <= 22) begin
            r.vy    = 5'sd5;   // top bar
            r.score = 1'b1;
         end else if (x <= 10) begin
            r.vx = vel_t'(ax);
         end else if (x >= 630) begin
            r.vx = vel_t'(-ax);
         end else if (y <= 10) begin
            r.vy = vel_t'(ay);
         end else begin
            r.hit = 1'b0;
         end
      end
   end
   return r;
endfunction

task automatic reset_model();
   exp_ball      = home_ball(1'b0);
   exp_rolling   = 1'b0;
   exp_flip_l    = 1'b0;
   exp_flip_r    = 1'b0;
   exp_bar       = 260;
   exp_bar_right = 1'b0;
   exp_score     = 1'b0;
   drains        = 0;
   hits          = 0;
endtask

// levels are the ones held up to the tick edge
task automatic advance_frame(input logic start_edge, input logic shake_in,
                             input logic bl, input logic br);
   bounce_t b;
   b         = bounce_for(exp_ball, exp_flip_l, exp_flip_r, exp_bar);
   exp_score = exp_rolling && b.score;
   hits      = hits + int'(exp_score);
   if (start_edge) begin
      exp_rolling = !exp_rolling;
      exp_ball    = home_ball(exp_rolling);
   end else if (exp_rolling && exp_ball.y >= 479) begin
      exp_rolling = 1'b0;   // out the bottom
      exp_ball    = home_ball(1'b0);
      drains++;
   end else if (exp_rolling) begin
      exp_ball.x  = coord_t'(int'(exp_ball.x) + int'(exp_ball.vx));
      exp_ball.y  = coord_t'(int'(exp_ball.y) + int'(exp_ball.vy));
      exp_ball.vx = shake_in ? vel_t'(-int'(b.vx)) : b.vx;
      exp_ball.vy = b.vy;
   end
   if (!exp_bar_right) begin
      if (exp_bar > 6) begin
         exp_bar = exp_bar - 6;
      end else begin
         exp_bar_right = 1'b1;   // turn, no move this frame
      end
   end else if (exp_bar < 639 - 6 - 80) begin
      exp_bar = exp_bar + 6;
   end else begin
      exp_bar_right = 1'b0;
   end
   exp_flip_l = bl;
   exp_flip_r = br;
endtask

`endif

/* tb/tb_pinball.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pinball;
   import pinball_pkg::*;

   localparam int tick_cycles  = 64;
   localparam int tick_timeout = 3 * tick_cycles;
   localparam int row_count    = 14;
   localparam int scene_count  = 12;

   typedef struct packed {
      logic [9:0] frames;
      logic       start;
      logic       btn_l;
      logic       btn_r;
      logic       shake;
      logic       rnd;   // buttons and shake from the lcg
   } row_t;

   typedef struct packed {
      pix_x_t x;
      pix_y_t y;
      logic   video_on;
      rgb_t   col;
   } scene_pix_t;

   localparam row_t stim [row_count] = '{
      '{10'd3,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0},   // parked while the bar sweeps
      '{10'd2,   1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
      '{10'd2,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
      '{10'd2,   1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
      '{10'd2,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
      '{10'd1,   1'b1, 1'b0, 1'b0, 1'b0, 1'b0},   // launch
      '{10'd60,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
      '{10'd30,  1'b0, 1'b1, 1'b1, 1'b0, 1'b0},
      '{10'd3,   1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
      '{10'd300, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
      '{10'd2,   1'b1, 1'b0, 1'b0, 1'b0, 1'b0},   // one edge held for two frames
      '{10'd5,   1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
      '{10'd1,   1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
      '{10'd400, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1}
   };

   localparam scene_pix_t scene [scene_count] = '{
      '{10'd5,   9'd150, 1'b1, col_wall},   // left panel
      '{10'd400, 9'd5,   1'b1, col_wall},   // top strip
      '{10'd50,  9'd400, 1'b1, col_wall},   // left slide
      '{10'd600, 9'd400, 1'b1, col_wall},
      '{10'd150, 9'd230, 1'b1, col_target},
      '{10'd300, 9'd160, 1'b1, col_target},
      '{10'd520, 9'd200, 1'b1, col_target},
      '{10'd125, 9'd80,  1'b1, col_fast},
      '{10'd400, 9'd300, 1'b1, col_black},
      '{10'd300, 9'd300, 1'b0, col_black},   // blanked
      '{10'd300, 9'd300, 1'b1, col_ball},    // parked ball at home
      '{10'd261, 9'd15,  1'b1, col_bar}
   };

   // ball centre and 7 px off each side
   localparam int off_x [5] = '{0, 7, -7, 0, 0};
   localparam int off_y [5] = '{0, 0, 0, 7, -7};

   logic        clk;
   logic        reset;
   logic        start_ball;
   logic        button_l;
   logic        button_r;
   logic        shake;
   pixel_t      pix;
   rgb_t        rgb;
   logic        score;
   int unsigned cyc;
   int          errors;
   int          checks;
   logic        stalled;
   logic [31:0] lcg_state;

   `include "pinball_model.svh"

   pinball_top #(
      .frame_cycles (tick_cycles)
   ) dut (
      .clk        (clk),
      .reset      (reset),
      .start_ball (start_ball),
      .button_l   (button_l),
      .button_r   (button_r),
      .shake      (shake),
      .pix        (pix),
      .rgb        (rgb),
      .score      (score)
   );

   always #5 clk = ~clk;

   // ticks land on every multiple of tick_cycles
   always @(posedge clk) begin
      if (reset) begin
         cyc <= 0;
      end else begin
         cyc <= cyc + 1;
      end
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic on_screen(int x, int y);
      return x >= 0 && x < 640 && y >= 0 && y < 480;
   endfunction

   task automatic check(input string name, input int got, input int exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   // called on a falling edge and the colour comes back a cycle later
   task automatic probe(input int x, input int y, input logic on, output rgb_t col);
      pix.x        = pix_x_t'(x);
      pix.y        = pix_y_t'(y);
      pix.video_on = on;
      @(negedge clk);
      col = rgb;
   endtask

   task automatic wait_tick();
      int n;
      for (n = 0; n < tick_timeout; n++) begin
         @(negedge clk);
         if (cyc != 0 && cyc % tick_cycles == 0) begin
            break;
         end
      end
      if (n == tick_timeout) begin
         stalled = 1'b1;
         $display("frame tick did not arrive within %0d cycles, run stopped", tick_timeout);
      end
   endtask

   task automatic flip_pixel(input int x, input int y, input logic lit);
      rgb_t col;
      if (!within_radius(x, y, int'(exp_ball.x), int'(exp_ball.y), 6)) begin
         probe(x, y, 1'b1, col);
         check($sformatf("rgb at (%0d,%0d)", x, y), col, lit ? col_flip : col_black);
      end
   endtask

   task automatic check_frame();
      rgb_t col;
      int   px;
      int   py;
      check("score", score, exp_score);
      for (int i = 0; i < 5; i++) begin
         px = int'(exp_ball.x) + off_x[i];
         py = int'(exp_ball.y) + off_y[i];
         if (on_screen(px, py)) begin
            probe(px, py, 1'b1, col);
            check($sformatf("rgb white at (%0d,%0d)", px, py), col == col_ball, i == 0);
         end
      end
      if (!within_radius(exp_bar + 1, 15, int'(exp_ball.x), int'(exp_ball.y), 6)) begin
         probe(exp_bar + 1, 15, 1'b1, col);
         check($sformatf("rgb at (%0d,15)", exp_bar + 1), col, col_bar);
      end
      probe(exp_bar - 1, 15, 1'b1, col);
      check($sformatf("rgb red at (%0d,15)", exp_bar - 1), col == col_bar, 0);
      flip_pixel(220, 420, exp_flip_l);    // raised left diagonal
      flip_pixel(200, 470, !exp_flip_l);
      flip_pixel(430, 430, exp_flip_r);
      flip_pixel(400, 470, !exp_flip_r);
   endtask

   initial begin
      row_t        row;
      rgb_t        col;
      logic [31:0] r;
      logic        st_prev;
      logic        bl;
      logic        br;
      logic        sh;
      int          err0;
      int          chk0;
      clk        = 1'b0;
      reset      = 1'b1;
      start_ball = 1'b0;
      button_l   = 1'b0;
      button_r   = 1'b0;
      shake      = 1'b0;
      pix        = '0;
      errors     = 0;
      checks     = 0;
      stalled    = 1'b0;
      st_prev    = 1'b0;
      lcg_state  = 32'h59c7eb23;
      reset_model();
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      for (int i = 0; i < scene_count; i++) begin
         probe(scene[i].x, scene[i].y, scene[i].video_on, col);
         check($sformatf("rgb at (%0d,%0d)", scene[i].x, scene[i].y), col, scene[i].col);
      end
      check_frame();
      $display("test static scene: %0d checks, %0d errors", checks, errors);

      for (int i = 0; i < row_count && !stalled; i++) begin
         row  = stim[i];
         err0 = errors;
         chk0 = checks;
         for (int f = 0; f < int'(row.frames); f++) begin
            bl = row.btn_l;
            br = row.btn_r;
            sh = row.shake;
            if (row.rnd) begin
               r  = next_rand();
               bl = r[16];
               br = r[17];
               sh = (r[22:20] == 3'd0);   // shakes kept rare
            end
            start_ball = row.start;
            button_l   = bl;
            button_r   = br;
            shake      = sh;
            wait_tick();
            if (stalled) begin
               break;
            end
            advance_frame(row.start && !st_prev, sh, bl, br);
            st_prev = row.start;
            check_frame();
         end
         $write("test row %0d: %0d frames, start %b, buttons %b%b, shake %b, random %b",
                i, row.frames, row.start, row.btn_l, row.btn_r, row.shake, row.rnd);
         $display(": %0d checks, %0d errors", checks - chk0, errors - err0);
      end

      $display("summary: %0d checks, %0d errors, %0d scoring frames, %0d drains",
               checks, errors, hits, drains);
      if (errors == 0 && !stalled) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* pinball.f */
+incdir+tb
hdl/pinball_pkg.sv
hdl/frame_ticker.sv
hdl/board_actuators.sv
hdl/collision_detect.sv
hdl/ball_physics.sv
hdl/pixel_renderer.sv
hdl/pinball_top.sv
tb/tb_pinball.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --assert -Wno-fatal
TOP       := tb_pinball
FLIST     := pinball.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST)) tb/pinball_model.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
